// File: source/eth_frame_pkg.sv
/*
 * Ethernet II frame layout seen by the transmit path.
 * CRC-32 is the reflected IEEE 802.3 form, one byte per call.
 * The FCS is the complement of the final register, LSB first on the wire.
 */
package eth_frame_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] ether_type_t;
    typedef logic [31:0] crc_t;

    // ==============================
    // Frame format
    // ==============================
    localparam byte_t     PREAMBLE_BYTE  = 8'h55;
    localparam byte_t     SFD_BYTE       = 8'hD5;
    localparam int        PREAMBLE_BYTES = 7;    // SFD not included
    localparam int        HEADER_BYTES   = 14;   // Dest + source + type
    localparam int        FCS_BYTES      = 4;
    localparam mac_addr_t BROADCAST_MAC  = 48'hFFFF_FFFF_FFFF;

    // ==============================
    // CRC-32
    // ==============================
    localparam crc_t CRC_INIT = 32'hFFFF_FFFF;
    localparam crc_t CRC_POLY = 32'hEDB8_8320;   // Reflected 0x04C11DB7

    // Bit-serial loop, unrolled by synthesis into one byte step
    function automatic crc_t crc32_next(crc_t crc, byte_t data);
        crc_t c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

endpackage

// File: source/mac_stream_pkg.sv
/*
 * Host-side data path types.
 * Payload words are little-endian, byte 0 in bits 7:0.
 * Payload lengths of 1 to 1500 bytes are legal, zero is not.
 */
package mac_stream_pkg;

    // ==============================
    // Host words
    // ==============================
    typedef logic [31:0] word_t;
    localparam int WORD_BYTES = 4;

    // ==============================
    // Lengths and status
    // ==============================
    typedef logic [15:0] length_t;        // Payload bytes, header and FCS excluded
    typedef logic [31:0] frame_count_t;   // Wraps silently

endpackage

// File: source/tx_payload_unpacker.sv
/*
 * Splits host payload words into a byte stream, one frame per descriptor.
 * The next descriptor is taken only after the last byte of the frame leaves.
 * A new word is taken in the cycle the previous word's last byte is accepted.
 */
`timescale 1ns/10ps

module tx_payload_unpacker
    import eth_frame_pkg::*;
    import mac_stream_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  length_t tx_len,
    input  logic    tx_len_valid,
    output logic    tx_len_ready,
    input  word_t   tx_data,
    input  logic    tx_data_valid,
    output logic    tx_data_ready,
    output byte_t   pay_byte,
    output logic    pay_valid,
    output logic    pay_last,
    input  logic    pay_ready
);

    localparam int IDX_W = $clog2(WORD_BYTES);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(WORD_BYTES - 1);

    logic             armed;        // Goes high on the first edge after reset
    logic             active;       // Descriptor taken, frame in progress
    logic             word_valid;
    logic [IDX_W-1:0] byte_idx;
    length_t          remaining;
    word_t            word_q;
    logic             byte_take;
    logic             word_done;

    assign pay_byte  = word_q[byte_idx*8 +: 8];
    assign pay_valid = word_valid;
    assign pay_last  = (remaining == length_t'(1));

    assign byte_take = pay_valid && pay_ready;
    assign word_done = byte_take && (byte_idx == IDX_LAST) && !pay_last;

    assign tx_len_ready  = armed && !active;
    assign tx_data_ready = active && (!word_valid || word_done);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed      <= 1'b0;
            active     <= 1'b0;
            word_valid <= 1'b0;
            byte_idx   <= '0;
            remaining  <= '0;
        end else begin
            armed <= 1'b1;
            if (tx_len_valid && tx_len_ready) begin
                active    <= 1'b1;
                remaining <= tx_len;
            end
            if (byte_take) begin
                remaining <= remaining - length_t'(1);
                byte_idx  <= byte_idx + IDX_W'(1);
                if (pay_last) begin
                    word_valid <= 1'b0;   // Drop unused high bytes
                    active     <= 1'b0;
                end else if (byte_idx == IDX_LAST) begin
                    word_valid <= 1'b0;
                end
            end
            // Reload wins over the clear above
            if (tx_data_valid && tx_data_ready) begin
                word_valid <= 1'b1;
                byte_idx   <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_data_valid && tx_data_ready) begin
            word_q <= tx_data;
        end
    end

    // Host must hold a waiting word unchanged
    a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_data_valid && !tx_data_ready) |=> (tx_data_valid && $stable(tx_data)))
        else $error("tx_data changed while waiting for tx_data_ready");

endmodule

// File: source/tx_header_inserter.sv
/*
 * Prepends broadcast destination, source MAC and EtherType to each frame.
 * The header starts only once the first payload byte is offered,
 * so a stalled host never leaves a half-sent header behind.
 */
`timescale 1ns/10ps

module tx_header_inserter
    import eth_frame_pkg::*;
#(
    parameter mac_addr_t   LOCAL_MAC  = 48'h02_00_00_00_00_01,
    parameter ether_type_t ETHER_TYPE = 16'h0800
) (
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t pay_byte,
    input  logic  pay_valid,
    input  logic  pay_last,
    output logic  pay_ready,
    output byte_t frm_byte,
    output logic  frm_valid,
    output logic  frm_last,
    input  logic  frm_ready
);

    localparam logic [HEADER_BYTES*8-1:0] HDR_BITS = {BROADCAST_MAC, LOCAL_MAC, ETHER_TYPE};
    localparam logic [3:0] HDR_LAST = 4'(HEADER_BYTES - 1);

    typedef enum logic {
        ST_HEADER,
        ST_PAYLOAD
    } state_t;

    state_t     state;
    logic [3:0] hdr_idx;
    byte_t      hdr_byte;

    // First header byte sits in the top bits
    assign hdr_byte = HDR_BITS[(HEADER_BYTES - 1 - int'(hdr_idx)) * 8 +: 8];

    assign frm_valid = pay_valid;   // Payload byte waiting means frame pending

    // ==============================
    // Stream mux
    // ==============================
    always_comb begin
        if (state == ST_HEADER) begin
            frm_byte  = hdr_byte;
            frm_last  = 1'b0;
            pay_ready = 1'b0;
        end else begin
            frm_byte  = pay_byte;
            frm_last  = pay_last;
            pay_ready = frm_ready;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_HEADER;
            hdr_idx <= '0;
        end else begin
            case (state)
                ST_HEADER: begin
                    if (frm_valid && frm_ready) begin
                        if (hdr_idx == HDR_LAST) begin
                            state   <= ST_PAYLOAD;
                            hdr_idx <= '0;
                        end else begin
                            hdr_idx <= hdr_idx + 4'd1;
                        end
                    end
                end
                ST_PAYLOAD: begin
                    if (pay_valid && pay_ready && pay_last) begin
                        state <= ST_HEADER;
                    end
                end
                default: state <= ST_HEADER;
            endcase
        end
    end

endmodule

// File: source/tx_fcs_inserter.sv
/*
 * Runs CRC-32 over header and payload and appends the four FCS bytes.
 * Frame bytes pass with zero latency; upstream is held off during the FCS.
 */
`timescale 1ns/10ps

module tx_fcs_inserter
    import eth_frame_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  byte_t frm_byte,
    input  logic  frm_valid,
    input  logic  frm_last,
    output logic  frm_ready,
    output byte_t fcs_byte,
    output logic  fcs_valid,
    output logic  fcs_last,
    input  logic  fcs_ready
);

    localparam logic [1:0] FCS_LAST = 2'(FCS_BYTES - 1);

    typedef enum logic {
        ST_PASS,
        ST_FCS
    } state_t;

    state_t     state;
    logic [1:0] fcs_idx;
    crc_t       crc_q;
    crc_t       fcs_val;

    assign fcs_val = ~crc_q;   // Final complement

    always_comb begin
        if (state == ST_PASS) begin
            fcs_byte  = frm_byte;
            fcs_valid = frm_valid;
            fcs_last  = 1'b0;   // Frame ends with the FCS, not here
            frm_ready = fcs_ready;
        end else begin
            fcs_byte  = fcs_val[fcs_idx*8 +: 8];
            fcs_valid = 1'b1;
            fcs_last  = (fcs_idx == FCS_LAST);
            frm_ready = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_PASS;
            fcs_idx <= '0;
            crc_q   <= CRC_INIT;
        end else begin
            case (state)
                ST_PASS: begin
                    if (frm_valid && frm_ready) begin
                        crc_q <= crc32_next(crc_q, frm_byte);
                        if (frm_last) begin
                            state   <= ST_FCS;
                            fcs_idx <= '0;
                        end
                    end
                end
                ST_FCS: begin
                    if (fcs_ready) begin
                        fcs_idx <= fcs_idx + 2'd1;
                        if (fcs_idx == FCS_LAST) begin
                            state <= ST_PASS;
                            crc_q <= CRC_INIT;   // Ready for next frame
                        end
                    end
                end
                default: state <= ST_PASS;
            endcase
        end
    end

    // Upstream stays blocked for at least the four FCS cycles
    a_fcs_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (frm_valid && frm_ready && frm_last) |=> !frm_ready [*4])
        else $error("frm_ready rose while FCS bytes were pending");

endmodule

// File: source/gmii_tx_driver.sv
/*
 * Drives registered GMII transmit outputs from the framed byte stream.
 * A missing byte mid-frame becomes one error cycle with zero data.
 * IFG_BYTES must be at least 1.
 */
`timescale 1ns/10ps

module gmii_tx_driver
    import eth_frame_pkg::*;
    import mac_stream_pkg::*;
#(
    parameter int IFG_BYTES = 12
) (
    input  logic         clk,
    input  logic         rst_n,
    input  byte_t        fcs_byte,
    input  logic         fcs_valid,
    input  logic         fcs_last,
    output logic         fcs_ready,
    output byte_t        gmii_tx_d,
    output logic         gmii_tx_en,
    output logic         gmii_tx_er,
    output frame_count_t frame_count
);

    localparam int CNT_MAX = (IFG_BYTES > PREAMBLE_BYTES) ? IFG_BYTES : PREAMBLE_BYTES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PREAMBLE,
        ST_DATA,
        ST_GAP
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;   // Preamble bytes sent, or gap cycles

    assign fcs_ready = (state == ST_DATA);

    // ==============================
    // Transmit FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            cnt         <= '0;
            gmii_tx_d   <= '0;
            gmii_tx_en  <= 1'b0;
            gmii_tx_er  <= 1'b0;
            frame_count <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    gmii_tx_d  <= '0;
                    gmii_tx_en <= 1'b0;
                    gmii_tx_er <= 1'b0;
                    if (fcs_valid) begin
                        gmii_tx_d  <= PREAMBLE_BYTE;   // First preamble byte
                        gmii_tx_en <= 1'b1;
                        cnt        <= CNT_W'(1);
                        state      <= ST_PREAMBLE;
                    end
                end
                ST_PREAMBLE: begin
                    if (cnt == CNT_W'(PREAMBLE_BYTES)) begin
                        gmii_tx_d <= SFD_BYTE;
                        state     <= ST_DATA;
                    end else begin
                        gmii_tx_d <= PREAMBLE_BYTE;
                        cnt       <= cnt + CNT_W'(1);
                    end
                end
                ST_DATA: begin
                    gmii_tx_en <= 1'b1;
                    if (fcs_valid) begin
                        gmii_tx_d  <= fcs_byte;
                        gmii_tx_er <= 1'b0;
                        if (fcs_last) begin
                            cnt   <= '0;
                            state <= ST_GAP;
                        end
                    end else begin
                        gmii_tx_d  <= '0;     // Underrun
                        gmii_tx_er <= 1'b1;
                    end
                end
                ST_GAP: begin
                    gmii_tx_d  <= '0;
                    gmii_tx_en <= 1'b0;
                    gmii_tx_er <= 1'b0;
                    if (cnt == '0) begin
                        frame_count <= frame_count + frame_count_t'(1);
                    end
                    if (cnt == CNT_W'(IFG_BYTES - 1)) begin
                        cnt   <= '0;
                        state <= ST_IDLE;
                    end else begin
                        cnt <= cnt + CNT_W'(1);
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // An error cycle sits inside a frame that carries on afterwards
    a_er_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        gmii_tx_er |-> gmii_tx_en ##1 gmii_tx_en)
        else $error("gmii_tx_er outside an active frame");

endmodule

// File: source/mac_tx_top.sv
/*
 * Gigabit Ethernet MAC, transmit only.
 * Host descriptor and payload channels in, GMII out. No padding to the
 * 46-byte minimum payload; short frames go out as given.
 */
`timescale 1ns/10ps

module mac_tx_top
    import eth_frame_pkg::*;
    import mac_stream_pkg::*;
#(
    parameter mac_addr_t   LOCAL_MAC  = 48'h02_00_00_00_00_01,
    parameter ether_type_t ETHER_TYPE = 16'h0800,
    parameter int          IFG_BYTES  = 12
) (
    input  logic         clk,
    input  logic         rst_n,
    input  length_t      tx_len,
    input  logic         tx_len_valid,
    output logic         tx_len_ready,
    input  word_t        tx_data,
    input  logic         tx_data_valid,
    output logic         tx_data_ready,
    output byte_t        gmii_tx_d,
    output logic         gmii_tx_en,
    output logic         gmii_tx_er,
    output frame_count_t frame_count
);

    // ==============================
    // Inter-stage byte streams
    // ==============================
    byte_t pay_byte, frm_byte, fcs_byte;
    logic  pay_valid, pay_last, pay_ready;
    logic  frm_valid, frm_last, frm_ready;
    logic  fcs_valid, fcs_last, fcs_ready;

    tx_payload_unpacker u_unpacker (
        .clk           (clk),
        .rst_n         (rst_n),
        .tx_len        (tx_len),
        .tx_len_valid  (tx_len_valid),
        .tx_len_ready  (tx_len_ready),
        .tx_data       (tx_data),
        .tx_data_valid (tx_data_valid),
        .tx_data_ready (tx_data_ready),
        .pay_byte      (pay_byte),
        .pay_valid     (pay_valid),
        .pay_last      (pay_last),
        .pay_ready     (pay_ready)
    );

    tx_header_inserter #(
        .LOCAL_MAC  (LOCAL_MAC),
        .ETHER_TYPE (ETHER_TYPE)
    ) u_header (
        .clk       (clk),
        .rst_n     (rst_n),
        .pay_byte  (pay_byte),
        .pay_valid (pay_valid),
        .pay_last  (pay_last),
        .pay_ready (pay_ready),
        .frm_byte  (frm_byte),
        .frm_valid (frm_valid),
        .frm_last  (frm_last),
        .frm_ready (frm_ready)
    );

    tx_fcs_inserter u_fcs (
        .clk       (clk),
        .rst_n     (rst_n),
        .frm_byte  (frm_byte),
        .frm_valid (frm_valid),
        .frm_last  (frm_last),
        .frm_ready (frm_ready),
        .fcs_byte  (fcs_byte),
        .fcs_valid (fcs_valid),
        .fcs_last  (fcs_last),
        .fcs_ready (fcs_ready)
    );

    gmii_tx_driver #(
        .IFG_BYTES (IFG_BYTES)
    ) u_gmii (
        .clk         (clk),
        .rst_n       (rst_n),
        .fcs_byte    (fcs_byte),
        .fcs_valid   (fcs_valid),
        .fcs_last    (fcs_last),
        .fcs_ready   (fcs_ready),
        .gmii_tx_d   (gmii_tx_d),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_tx_er  (gmii_tx_er),
        .frame_count (frame_count)
    );

endmodule

// File: tests/gmii_frame_checker.sv
/*
 * Samples GMII on the falling clock edge and rebuilds each frame from tx_en.
 * Error cycles are dropped from the byte list; the tb queues the expected
 * bytes, their count and whether an underrun is due, one entry per frame.
 */
`timescale 1ns/10ps

module gmii_frame_checker
    import eth_frame_pkg::*;
    import mac_stream_pkg::*;
#(
    parameter int IFG_BYTES = 12
) (
    input  logic         clk,
    input  logic         rst_n,
    input  byte_t        gmii_tx_d,
    input  logic         gmii_tx_en,
    input  logic         gmii_tx_er,
    input  frame_count_t frame_count,
    output int           err_count,
    output int           frames_done
);

    byte_t exp_bytes[$];      // Filled by the tb
    int    exp_lens[$];
    logic  exp_underrun[$];

    byte_t got[$];
    logic  in_frame;
    logic  er_seen;
    logic  seen_frame;
    int    gap_cycles;

    task automatic log_mismatch(string msg);
        err_count++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic log_problem(string msg);
        err_count++;
        $display("At %0t something went wrong: %s", $time, msg);
    endtask

    // ==============================
    // Frame compare
    // ==============================
    task automatic compare_frame();
        int    n;
        int    bad;
        logic  under;
        byte_t b;
        byte_t bad_exp;
        if (exp_lens.size() == 0) begin
            log_problem("a frame appeared on GMII with no frame queued");
            got.delete();
            return;
        end
        n       = exp_lens.pop_front();
        under   = exp_underrun.pop_front();
        bad     = -1;
        bad_exp = '0;
        for (int i = 0; i < n; i++) begin
            b = exp_bytes.pop_front();
            if (bad < 0 && (i >= got.size() || got[i] !== b)) begin
                bad     = i;
                bad_exp = b;
            end
        end
        if (got.size() != n) begin
            log_mismatch($sformatf("frame %0d has %0d bytes, expected %0d",
                frames_done, got.size(), n));
        end else if (bad >= 0) begin
            log_mismatch($sformatf("frame %0d byte %0d is %02h, expected %02h",
                frames_done, bad, got[bad], bad_exp));
        end
        if (er_seen !== under) begin
            log_mismatch($sformatf("frame %0d tx_er seen %0b, expected %0b",
                frames_done, er_seen, under));
        end
        frames_done++;
        got.delete();
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            err_count   = 0;
            frames_done = 0;
            in_frame    = 1'b0;
            er_seen     = 1'b0;
            seen_frame  = 1'b0;
            gap_cycles  = 0;
        end else begin
            if (gmii_tx_er && !gmii_tx_en) begin
                log_problem("tx_er is high while tx_en is low");
            end
            if (gmii_tx_en) begin
                if (!in_frame) begin
                    if (seen_frame && gap_cycles != IFG_BYTES) begin
                        log_mismatch($sformatf("gap of %0d cycles, expected %0d",
                            gap_cycles, IFG_BYTES));
                    end
                    in_frame = 1'b1;
                    er_seen  = 1'b0;
                end
                if (gmii_tx_er) begin
                    er_seen = 1'b1;
                    if (gmii_tx_d !== 8'h00) begin
                        log_mismatch("data not zero in an error cycle");
                    end
                end else begin
                    got.push_back(gmii_tx_d);
                end
            end else begin
                if (in_frame) begin
                    compare_frame();
                    // Counter steps on the same edge that drops tx_en
                    if (frame_count !== frame_count_t'(frames_done)) begin
                        log_mismatch($sformatf("frame_count %0d, expected %0d",
                            frame_count, frames_done));
                    end
                    in_frame   = 1'b0;
                    seen_frame = 1'b1;
                    gap_cycles = 0;
                end
                gap_cycles++;
            end
        end
    end

endmodule

// File: tests/tb_mac_tx.sv
/*
 * Testbench for the transmit MAC with default parameters.
 * Frames go back to back; stalls fall only before the third word onward,
 * so a stall of 4 or more cycles always starves the GMII side.
 */
`timescale 1ns/10ps

module tb_mac_tx
    import eth_frame_pkg::*;
    import mac_stream_pkg::*;
;

    typedef byte_t byte_q_t[$];

    localparam logic [47:0] SRC_MAC = 48'h02_00_00_00_00_01;

    logic         clk = 1'b0;
    logic         rst_n;
    length_t      tx_len;
    logic         tx_len_valid;
    logic         tx_len_ready;
    word_t        tx_data;
    logic         tx_data_valid;
    logic         tx_data_ready;
    byte_t        gmii_tx_d;
    logic         gmii_tx_en;
    logic         gmii_tx_er;
    frame_count_t frame_count;
    int           err_count;
    int           frames_done;
    int           tb_errors = 0;
    int           limit_cycles = 0;
    logic [31:0]  lfsr_q = 32'he1b4_0e4d;
    int           frame_lens[$];
    logic         frame_stall[$];

    always #20 clk = ~clk;

    mac_tx_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .tx_len        (tx_len),
        .tx_len_valid  (tx_len_valid),
        .tx_len_ready  (tx_len_ready),
        .tx_data       (tx_data),
        .tx_data_valid (tx_data_valid),
        .tx_data_ready (tx_data_ready),
        .gmii_tx_d     (gmii_tx_d),
        .gmii_tx_en    (gmii_tx_en),
        .gmii_tx_er    (gmii_tx_er),
        .frame_count   (frame_count)
    );

    gmii_frame_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .gmii_tx_d   (gmii_tx_d),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_tx_er  (gmii_tx_er),
        .frame_count (frame_count),
        .err_count   (err_count),
        .frames_done (frames_done)
    );

    // ==============================
    // Random source and reference
    // ==============================
    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_q[0]);
            lfsr_q = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [31:0] crc_step(logic [31:0] crc, byte_t b);
        logic fb;
        for (int k = 0; k < 8; k++) begin
            fb  = crc[0] ^ b[k];   // Bits go out LSB first
            crc = crc >> 1;
            if (fb) begin
                crc = crc ^ 32'hEDB8_8320;
            end
        end
        return crc;
    endfunction

    function automatic byte_q_t ref_frame(byte_q_t payload);
        byte_q_t     f;
        logic [31:0] crc;
        f = {};
        repeat (7) f.push_back(8'h55);
        f.push_back(8'hD5);
        repeat (6) f.push_back(8'hFF);
        for (int i = 0; i < 6; i++) begin
            f.push_back(SRC_MAC[47 - 8*i -: 8]);
        end
        f.push_back(8'h08);
        f.push_back(8'h00);
        foreach (payload[i]) f.push_back(payload[i]);
        crc = 32'hFFFF_FFFF;
        for (int i = 8; i < f.size(); i++) begin   // CRC starts after the SFD
            crc = crc_step(crc, f[i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            f.push_back(crc[i*8 +: 8]);
        end
        return f;
    endfunction

    // ==============================
    // Host side
    // ==============================
    task automatic wait_len_taken();
        @(negedge clk);
        while (!tx_len_ready) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic wait_data_taken();
        @(negedge clk);
        while (!tx_data_ready) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic send_frame(int len, logic force_stall);
        byte_q_t payload;
        byte_q_t exp;
        int      stalls[$];
        int      nwords;
        int      idx;
        logic    under;
        word_t   w;
        payload = {};
        under   = 1'b0;
        nwords  = (len + 3) / 4;
        for (int i = 0; i < len; i++) begin
            payload.push_back(byte_t'(rand_bits(8)));
        end
        for (int wi = 0; wi < nwords; wi++) begin
            stalls.push_back(0);
            if (wi >= 2) begin
                if (force_stall && wi == 2) stalls[wi] = 6;
                else if (rand_bits(2) == 0) stalls[wi] = rand_bits(3);
                if (stalls[wi] >= 4) under = 1'b1;
            end
        end
        exp = ref_frame(payload);
        foreach (exp[i]) u_checker.exp_bytes.push_back(exp[i]);
        u_checker.exp_lens.push_back(exp.size());
        u_checker.exp_underrun.push_back(under);

        tx_len       <= length_t'(len);
        tx_len_valid <= 1'b1;
        wait_len_taken();
        tx_len_valid <= 1'b0;
        for (int wi = 0; wi < nwords; wi++) begin
            if (stalls[wi] > 0) begin
                tx_data_valid <= 1'b0;
                repeat (stalls[wi]) @(posedge clk);
            end
            for (int b = 0; b < 4; b++) begin
                idx = wi*4 + b;
                w[b*8 +: 8] = (idx < len) ? payload[idx] : byte_t'(rand_bits(8)); // Junk tail
            end
            tx_data       <= w;
            tx_data_valid <= 1'b1;
            wait_data_taken();
        end
        tx_data_valid <= 1'b0;
    endtask

    // Ends the run if frames stop coming out
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the run hung, %0d of %0d frames done after %0d cycles",
            frames_done, frame_lens.size(), limit_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int budget;
        rst_n         = 1'b0;
        tx_len        = '0;
        tx_len_valid  = 1'b0;
        tx_data       = '0;
        tx_data_valid = 1'b0;
        frame_lens    = {1, 2, 3, 4, 5, 64, 64};
        frame_stall   = {0, 0, 0, 0, 0, 0, 1};
        repeat (6) begin
            frame_lens.push_back(1 + (rand_bits(11) % 1500));
            frame_stall.push_back(1'b0);
        end
        budget = 200;
        foreach (frame_lens[i]) budget += 4 * (frame_lens[i] + 38);
        limit_cycles = budget;

        repeat (5) @(posedge clk);
        @(negedge clk);
        if (tx_len_ready || tx_data_ready || gmii_tx_en || gmii_tx_er || frame_count != 0) begin
            tb_errors++;
            $display("Error at %0t: outputs not in reset state", $time);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        foreach (frame_lens[i]) send_frame(frame_lens[i], frame_stall[i]);
        while (frames_done < frame_lens.size()) @(negedge clk);
        repeat (4) @(posedge clk);

        $display("Closing report: %0d frames checked, %0d checker errors, %0d tb errors",
            frames_done, err_count, tb_errors);
        if (err_count == 0 && tb_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
source/eth_frame_pkg.sv
source/mac_stream_pkg.sv
source/tx_payload_unpacker.sv
source/tx_header_inserter.sv
source/tx_fcs_inserter.sv
source/gmii_tx_driver.sv
source/mac_tx_top.sv
tests/gmii_frame_checker.sv
tests/tb_mac_tx.sv

// File: run_sim.sh
#!/bin/sh
# Builds the MAC transmit testbench with Verilator and runs it.
# Exit status is non-zero when the build, the run or any check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module tb_mac_tx --Mdir "$OBJ" -o tb_mac_tx
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/tb_mac_tx" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi

if ! grep -q "SIMULATION PASSED" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi

exit 0
